/* rdma_pkg.sv */
// Field layout of the engine send-queue command and acknowledgement words
// Offsets are fixed by the engine and must match its build
// Only the four opcodes in rdma_opcode_e are accepted by the bridge
`default_nettype none

package rdma_pkg;

  // Request field widths
  localparam int OPCODE_BITS = 5;
  localparam int PID_BITS = 6;
  localparam int VFID_BITS = 4;

  // Queue pair number, vfid above pid, upper bits zero
  localparam int QPN_BITS = 24;

  // Real virtual address and the slot it travels in
  localparam int VADDR_BITS = 48;
  localparam int VADDR_SLOT_BITS = 64;

  // Transfer length in bytes
  localparam int LEN_BITS = 32;

  // Opcode sits at bit 0, qpn at bit 32 in both words
  localparam int QPN_OFFS = 32;

  // Flags right above the qpn
  localparam int HOST_OFFS = QPN_OFFS + QPN_BITS;
  localparam int LAST_OFFS = HOST_OFFS + 1;

  // Address slot, then length
  localparam int VADDR_OFFS = LAST_OFFS + 1;
  localparam int LEN_OFFS = VADDR_OFFS + VADDR_SLOT_BITS;

  // Flat word widths seen by the engine
  localparam int CMD_BITS = LEN_OFFS + LEN_BITS;
  localparam int ACK_BITS = 64;

  // Opcodes the engine supports
  // Anything else is dropped at decode
  typedef enum logic [OPCODE_BITS-1:0] {
    RDMA_READ  = 5'd0,
    RDMA_WRITE = 5'd1,
    RDMA_SEND  = 5'd2,
    RDMA_IMMED = 5'd3
  } rdma_opcode_e;

  // Occupancy of a single-entry pipeline register
  typedef enum logic {
    EMPTY = 1'b0,
    FULL  = 1'b1
  } stage_state_e;

endpackage

`default_nettype wire

/* rdma_sq_if.sv */
// Decoded send-queue request between decode and command packing
// Valid/ready, data held stable by the source until the transfer
`default_nettype none

interface rdma_sq_if;
  import rdma_pkg::*;

  // Handshake
  logic valid;
  logic ready;

  // Decoded request
  rdma_opcode_e opcode;
  logic [QPN_BITS-1:0] qpn;
  logic [VADDR_BITS-1:0] vaddr;
  logic [LEN_BITS-1:0] len;
  logic host;
  logic last;

  // Decode side
  modport src (
    output valid, opcode, qpn, vaddr, len, host, last,
    input ready
  );

  // Packing side
  modport dst (
    input valid, opcode, qpn, vaddr, len, host, last,
    output ready
  );

endinterface

`default_nettype wire

/* sq_decode.sv */
// Accepts one user request at a time, drops illegal opcodes
// Drop counter saturates at its maximum and only clears on reset
`default_nettype none

module sq_decode #(
  parameter int DROP_CNT_BITS = 16
) (
  input  wire logic                             nclk,
  input  wire logic                             arst_n,
  input  wire logic                             req_valid,
  output logic                                  req_ready,
  input  wire logic [rdma_pkg::OPCODE_BITS-1:0] req_opcode,
  input  wire logic [rdma_pkg::PID_BITS-1:0]    req_pid,
  input  wire logic [rdma_pkg::VFID_BITS-1:0]   req_vfid,
  input  wire logic [rdma_pkg::VADDR_BITS-1:0]  req_vaddr,
  input  wire logic [rdma_pkg::LEN_BITS-1:0]    req_len,
  input  wire logic                             req_host,
  input  wire logic                             req_last,
  rdma_sq_if.src                                sq,
  output logic [DROP_CNT_BITS-1:0]              drop_count
);
  import rdma_pkg::*;

  stage_state_e state_q;
  rdma_opcode_e req_op;
  logic op_legal;
  logic req_xfer;
  logic sq_xfer;
  rdma_opcode_e op_q;
  logic [QPN_BITS-1:0] qpn_q;
  logic [VADDR_BITS-1:0] vaddr_q;
  logic [LEN_BITS-1:0] len_q;
  logic host_q;
  logic last_q;
  logic [DROP_CNT_BITS-1:0] drop_q;

  // Opcode check against the enum
  always_comb begin
    req_op = rdma_opcode_e'(req_opcode);
    case (req_op)
      RDMA_READ, RDMA_WRITE, RDMA_SEND, RDMA_IMMED: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  end

  // Stage frees up in the same cycle it drains
  assign sq_xfer = sq.valid && sq.ready;
  assign req_ready = (state_q == EMPTY) || sq_xfer;
  assign req_xfer = req_valid && req_ready;

  // Stage occupancy, only legal requests fill it
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= EMPTY;
    end else if (req_xfer && op_legal) begin
      state_q <= FULL;
    end else if (sq_xfer) begin
      state_q <= EMPTY;
    end
  end

  // Request payload
  always_ff @(posedge nclk) begin
    if (req_xfer && op_legal) begin
      op_q <= req_op;
      qpn_q <= {{(QPN_BITS-VFID_BITS-PID_BITS){1'b0}}, req_vfid, req_pid};
      vaddr_q <= req_vaddr;
      len_q <= req_len;
      host_q <= req_host;
      last_q <= req_last;
    end
  end

  // Dropped request count, sticks at all ones
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      drop_q <= '0;
    end else if (req_xfer && !op_legal && (drop_q != {DROP_CNT_BITS{1'b1}})) begin
      drop_q <= drop_q + 1'b1;
    end
  end

  assign drop_count = drop_q;

  // Toward the packer
  assign sq.valid = (state_q == FULL);
  assign sq.opcode = op_q;
  assign sq.qpn = qpn_q;
  assign sq.vaddr = vaddr_q;
  assign sq.len = len_q;
  assign sq.host = host_q;
  assign sq.last = last_q;

  // Held request must not change while the packer stalls
  a_sq_stable: assert property (@(posedge nclk) disable iff (!arst_n)
    sq.valid && !sq.ready |=> sq.valid &&
      $stable({sq.opcode, sq.qpn, sq.vaddr, sq.len, sq.host, sq.last}));

endmodule

`default_nettype wire

/* sq_cmd_pack.sv */
// Packs a decoded request into the flat engine command word
// Unused bits and the address slot padding are always zero
`default_nettype none

module sq_cmd_pack (
  input  wire logic                        nclk,
  input  wire logic                        arst_n,
  rdma_sq_if.dst                           sq,
  output logic                             cmd_valid,
  input  wire logic                        cmd_ready,
  output logic [rdma_pkg::CMD_BITS-1:0]    cmd_data
);
  import rdma_pkg::*;

  stage_state_e state_q;
  logic sq_xfer;
  logic cmd_xfer;
  logic [CMD_BITS-1:0] cmd_next;
  logic [CMD_BITS-1:0] cmd_q;

  // Word layout
  always_comb begin
    cmd_next = '0;
    cmd_next[0 +: OPCODE_BITS] = sq.opcode;
    cmd_next[QPN_OFFS +: QPN_BITS] = sq.qpn;
    cmd_next[HOST_OFFS] = sq.host;
    cmd_next[LAST_OFFS] = sq.last;
    // 48-bit address, zero upper part of the slot
    cmd_next[VADDR_OFFS +: VADDR_SLOT_BITS] =
      {{(VADDR_SLOT_BITS-VADDR_BITS){1'b0}}, sq.vaddr};
    cmd_next[LEN_OFFS +: LEN_BITS] = sq.len;
  end

  assign cmd_valid = (state_q == FULL);
  assign cmd_xfer = cmd_valid && cmd_ready;

  // Accept while empty or draining
  assign sq.ready = (state_q == EMPTY) || cmd_xfer;
  assign sq_xfer = sq.valid && sq.ready;

  // Output register occupancy
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= EMPTY;
    end else if (sq_xfer) begin
      state_q <= FULL;
    end else if (cmd_xfer) begin
      state_q <= EMPTY;
    end
  end

  // Command word, held under back-pressure
  always_ff @(posedge nclk) begin
    if (sq_xfer) begin
      cmd_q <= cmd_next;
    end
  end

  assign cmd_data = cmd_q;

  // Engine side must see valid held until taken
  a_cmd_hold: assert property (@(posedge nclk) disable iff (!arst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data));

endmodule

`default_nettype wire

/* ack_unpack.sv */
// Unpacks the engine acknowledgement word into completion fields
// Opcode is passed on unchecked, the engine only sends legal codes
`default_nettype none

module ack_unpack (
  input  wire logic                           nclk,
  input  wire logic                           arst_n,
  input  wire logic                           ack_valid,
  output logic                                ack_ready,
  input  wire logic [rdma_pkg::ACK_BITS-1:0]  ack_data,
  output logic                                cpl_valid,
  input  wire logic                           cpl_ready,
  output rdma_pkg::rdma_opcode_e              cpl_opcode,
  output logic [rdma_pkg::PID_BITS-1:0]       cpl_pid,
  output logic [rdma_pkg::VFID_BITS-1:0]      cpl_vfid,
  output logic                                cpl_host,
  output logic                                cpl_last
);
  import rdma_pkg::*;

  logic ack_xfer;
  logic cpl_xfer;

  assign cpl_xfer = cpl_valid && cpl_ready;
  // Take a new word when empty or being read
  assign ack_ready = !cpl_valid || cpl_ready;
  assign ack_xfer = ack_valid && ack_ready;

  // Completion valid
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      cpl_valid <= 1'b0;
    end else if (ack_xfer) begin
      cpl_valid <= 1'b1;
    end else if (cpl_xfer) begin
      cpl_valid <= 1'b0;
    end
  end

  // Field slices, pid low in the qpn and vfid above it
  always_ff @(posedge nclk) begin
    if (ack_xfer) begin
      cpl_opcode <= rdma_opcode_e'(ack_data[0 +: OPCODE_BITS]);
      cpl_pid <= ack_data[QPN_OFFS +: PID_BITS];
      cpl_vfid <= ack_data[QPN_OFFS+PID_BITS +: VFID_BITS];
      cpl_host <= ack_data[HOST_OFFS];
      cpl_last <= ack_data[LAST_OFFS];
    end
  end

  // Completion held until the user takes it
  a_cpl_hold: assert property (@(posedge nclk) disable iff (!arst_n)
    cpl_valid && !cpl_ready |=> cpl_valid);

endmodule

`default_nettype wire

/* rdma_cmd_bridge.sv */
// Command bridge between a user send queue and the RoCE engine
// Request path is two stages deep, illegal opcodes are only counted
// Ack path is a single register stage
`default_nettype none

module rdma_cmd_bridge #(
  parameter int DROP_CNT_BITS = 16
) (
  input  wire logic                             nclk,
  input  wire logic                             arst_n,
  // User request
  input  wire logic                             req_valid,
  output logic                                  req_ready,
  input  wire logic [rdma_pkg::OPCODE_BITS-1:0] req_opcode,
  input  wire logic [rdma_pkg::PID_BITS-1:0]    req_pid,
  input  wire logic [rdma_pkg::VFID_BITS-1:0]   req_vfid,
  input  wire logic [rdma_pkg::VADDR_BITS-1:0]  req_vaddr,
  input  wire logic [rdma_pkg::LEN_BITS-1:0]    req_len,
  input  wire logic                             req_host,
  input  wire logic                             req_last,
  // Engine command
  output logic                                  cmd_valid,
  input  wire logic                             cmd_ready,
  output logic [rdma_pkg::CMD_BITS-1:0]         cmd_data,
  // Engine ack
  input  wire logic                             ack_valid,
  output logic                                  ack_ready,
  input  wire logic [rdma_pkg::ACK_BITS-1:0]    ack_data,
  // User completion
  output logic                                  cpl_valid,
  input  wire logic                             cpl_ready,
  output rdma_pkg::rdma_opcode_e                cpl_opcode,
  output logic [rdma_pkg::PID_BITS-1:0]         cpl_pid,
  output logic [rdma_pkg::VFID_BITS-1:0]        cpl_vfid,
  output logic                                  cpl_host,
  output logic                                  cpl_last,
  output logic [DROP_CNT_BITS-1:0]              drop_count
);

  // Decode to packing link
  rdma_sq_if sq_if ();

  sq_decode #(
    .DROP_CNT_BITS(DROP_CNT_BITS)
  ) u_sq_decode (
    .nclk(nclk), .arst_n(arst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_opcode(req_opcode),
    .req_pid(req_pid), .req_vfid(req_vfid), .req_vaddr(req_vaddr),
    .req_len(req_len), .req_host(req_host), .req_last(req_last),
    .sq(sq_if.src), .drop_count(drop_count)
  );

  sq_cmd_pack u_sq_cmd_pack (
    .nclk(nclk), .arst_n(arst_n), .sq(sq_if.dst),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data)
  );

  ack_unpack u_ack_unpack (
    .nclk(nclk), .arst_n(arst_n),
    .ack_valid(ack_valid), .ack_ready(ack_ready), .ack_data(ack_data),
    .cpl_valid(cpl_valid), .cpl_ready(cpl_ready), .cpl_opcode(cpl_opcode),
    .cpl_pid(cpl_pid), .cpl_vfid(cpl_vfid),
    .cpl_host(cpl_host), .cpl_last(cpl_last)
  );

endmodule

`default_nettype wire

/* tb_rdma_cmd_bridge.sv */
// Reads its vectors from rdma_cmd_bridge_testdata.txt and runs from the project root
// Holds at most MAX_VEC vectors and the list ends at the first kind of zero
// Inputs change on the falling edge and outputs are sampled 1 ns later
`default_nettype none

module tb_rdma_cmd_bridge;
  timeunit 1ns;
  timeprecision 1ps;
  import rdma_pkg::*;

  localparam int FIELDS = 10;
  localparam int MAX_VEC = 32;

  logic nclk;
  logic arst_n;
  logic req_valid;
  logic req_ready;
  logic [OPCODE_BITS-1:0] req_opcode;
  logic [PID_BITS-1:0] req_pid;
  logic [VFID_BITS-1:0] req_vfid;
  logic [VADDR_BITS-1:0] req_vaddr;
  logic [LEN_BITS-1:0] req_len;
  logic req_host;
  logic req_last;
  logic cmd_valid;
  logic cmd_ready;
  logic [CMD_BITS-1:0] cmd_data;
  logic ack_valid;
  logic ack_ready;
  logic [ACK_BITS-1:0] ack_data;
  logic cpl_valid;
  logic cpl_ready;
  rdma_opcode_e cpl_opcode;
  logic [PID_BITS-1:0] cpl_pid;
  logic [VFID_BITS-1:0] cpl_vfid;
  logic cpl_host;
  logic cpl_last;
  logic [15:0] drop_count;

  // One row of FIELDS words per vector
  logic [159:0] tdata [0:FIELDS*MAX_VEC-1];
  int req_vecs[$];
  int ack_vecs[$];
  int n_vec;
  int errors;
  int tests_run;
  int tests_failed;
  int drops_exp;
  int cycle_count;
  int cycle_limit;
  logic [31:0] rng;

  rdma_cmd_bridge #(
    .DROP_CNT_BITS(16)
  ) DUT (.*);

  always #10 nclk = ~nclk;

  // Watchdog
  always @(posedge nclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic int row(input int v, input int f);
    return v * FIELDS + f;
  endfunction

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input logic [159:0] got, input logic [159:0] expected,
                             input string what);
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got,
               expected);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("Error at %0d ns: %s", $time, what);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // All request vectors in order and back to back with optional cmd_ready stalls
  task automatic run_requests(input bit stall, input string name);
    int e0;
    int next;
    int iter;
    int cur;
    int v;
    int a;
    int full_seen;
    int pend[$];
    int acc_iter[$];
    bit taken;
    e0 = errors;
    next = 0;
    iter = 0;
    cur = 0;
    full_seen = 0;
    taken = 1'b0;
    do begin
      @(negedge nclk);
      if (taken) begin
        req_valid = 1'b0;
      end
      taken = 1'b0;
      if (!req_valid && next < req_vecs.size()) begin
        cur = req_vecs[next];
        next++;
        req_opcode = tdata[row(cur, 1)][OPCODE_BITS-1:0];
        req_pid = tdata[row(cur, 2)][PID_BITS-1:0];
        req_vfid = tdata[row(cur, 3)][VFID_BITS-1:0];
        req_vaddr = tdata[row(cur, 4)][VADDR_BITS-1:0];
        req_len = tdata[row(cur, 5)][LEN_BITS-1:0];
        req_host = tdata[row(cur, 6)][0];
        req_last = tdata[row(cur, 7)][0];
        req_valid = 1'b1;
      end
      rng = xorshift32(rng);
      cmd_ready = stall ? rng[3] : 1'b1;
      #1;
      // Counter lags an illegal acceptance by one cycle
      check_value(160'(drop_count), 160'(drops_exp), "drop_count");
      if (cmd_valid && cmd_ready) begin
        if (pend.size() == 0) begin
          report_fault("command word came out with no legal request outstanding");
        end else begin
          v = pend.pop_front();
          a = acc_iter.pop_front();
          check_value(160'(cmd_data), tdata[row(v, 8)],
                      $sformatf("command word of vector %0d", v));
          if (!stall) begin
            check_value(160'(iter), 160'(a + 2), $sformatf("latency of vector %0d", v));
          end
        end
      end
      // Stall only possible with both stages full
      if (req_valid && !req_ready) begin
        if (!stall) begin
          report_fault("req_ready fell while cmd_ready was held high");
        end else if (cmd_valid && !cmd_ready) begin
          full_seen++;
        end else begin
          report_fault("req_ready fell while a pipeline stage was free");
        end
      end
      if (req_valid && req_ready) begin
        taken = 1'b1;
        if (tdata[row(cur, 9)][0]) begin
          pend.push_back(cur);
          acc_iter.push_back(iter);
        end else begin
          drops_exp++;
        end
      end
      iter++;
    end while (next < req_vecs.size() || (req_valid && !taken) || pend.size() > 0);
    @(negedge nclk);
    req_valid = 1'b0;
    cmd_ready = 1'b1;
    #1;
    check_value(160'(cmd_valid), 160'(0), "cmd_valid after the last command");
    check_value(160'(drop_count), 160'(drops_exp), "drop_count at end of test");
    if (stall && full_seen == 0) begin
      report_fault("req_ready never fell, both stages were never full");
    end
    end_test(name, e0);
  endtask

  // Ack vectors back to back under random cpl_ready
  task automatic run_acks(input string name);
    int e0;
    int next;
    int cur;
    int v;
    int pend[$];
    bit taken;
    e0 = errors;
    next = 0;
    cur = 0;
    taken = 1'b0;
    do begin
      @(negedge nclk);
      if (taken) begin
        ack_valid = 1'b0;
      end
      taken = 1'b0;
      if (!ack_valid && next < ack_vecs.size()) begin
        cur = ack_vecs[next];
        next++;
        ack_data = tdata[row(cur, 4)][ACK_BITS-1:0];
        ack_valid = 1'b1;
      end
      rng = xorshift32(rng);
      cpl_ready = rng[3];
      #1;
      if (cpl_valid && cpl_ready) begin
        if (pend.size() == 0) begin
          report_fault("completion came out with no acknowledgement outstanding");
        end else begin
          v = pend.pop_front();
          check_value(160'(cpl_opcode), tdata[row(v, 1)], $sformatf("cpl_opcode, vector %0d", v));
          check_value(160'(cpl_pid), tdata[row(v, 2)], $sformatf("cpl_pid, vector %0d", v));
          check_value(160'(cpl_vfid), tdata[row(v, 3)], $sformatf("cpl_vfid, vector %0d", v));
          check_value(160'(cpl_host), tdata[row(v, 6)], $sformatf("cpl_host, vector %0d", v));
          check_value(160'(cpl_last), tdata[row(v, 7)], $sformatf("cpl_last, vector %0d", v));
        end
      end
      if (!ack_ready && !(cpl_valid && !cpl_ready)) begin
        report_fault("ack_ready low while the completion register could take a word");
      end
      if (ack_valid && ack_ready) begin
        taken = 1'b1;
        pend.push_back(cur);
      end
    end while (next < ack_vecs.size() || (ack_valid && !taken) || pend.size() > 0);
    @(negedge nclk);
    ack_valid = 1'b0;
    cpl_ready = 1'b1;
    #1;
    check_value(160'(cpl_valid), 160'(0), "cpl_valid after the last completion");
    end_test(name, e0);
  endtask

  initial begin
    int i;
    int e0;
    nclk = 1'b0;
    arst_n = 1'b0;
    req_valid = 1'b0;
    req_opcode = '0;
    req_pid = '0;
    req_vfid = '0;
    req_vaddr = '0;
    req_len = '0;
    req_host = 1'b0;
    req_last = 1'b0;
    cmd_ready = 1'b1;
    ack_valid = 1'b0;
    ack_data = '0;
    cpl_ready = 1'b1;
    rng = 32'd62;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    drops_exp = 0;
    cycle_limit = 0;
    for (i = 0; i < FIELDS * MAX_VEC; i++) begin
      tdata[i] = '0;
    end
    $readmemh("rdma_cmd_bridge_testdata.txt", tdata);
    // Sort vectors by kind
    n_vec = 0;
    while (n_vec < MAX_VEC && tdata[row(n_vec, 0)] != 0) begin
      if (tdata[row(n_vec, 0)] == 1) begin
        req_vecs.push_back(n_vec);
      end else begin
        ack_vecs.push_back(n_vec);
      end
      n_vec++;
    end
    if (req_vecs.size() == 0 || ack_vecs.size() == 0) begin
      report_fault("data file held no request or no acknowledgement vectors");
    end
    cycle_limit = 40 * n_vec + 100;
    // Three rising edges in reset
    repeat (3) @(posedge nclk);
    @(negedge nclk);
    arst_n = 1'b1;
    #1;
    e0 = errors;
    check_value(160'(cmd_valid), 160'(0), "cmd_valid after reset");
    check_value(160'(cpl_valid), 160'(0), "cpl_valid after reset");
    check_value(160'(req_ready), 160'(1), "req_ready after reset");
    check_value(160'(ack_ready), 160'(1), "ack_ready after reset");
    check_value(160'(drop_count), 160'(0), "drop_count after reset");
    end_test("reset state", e0);
    run_requests(1'b0, "back-to-back requests");
    run_requests(1'b1, "requests under cmd_ready stalls");
    run_acks("acknowledgement unpacking");
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rdma_cmd_bridge.f */
rdma_pkg.sv
rdma_sq_if.sv
sq_decode.sv
sq_cmd_pack.sv
ack_unpack.sv
rdma_cmd_bridge.sv
tb_rdma_cmd_bridge.sv

/* Bender.yml */
package:
  name: rdma_cmd_bridge

sources:
  - rdma_pkg.sv
  - rdma_sq_if.sv
  - sq_decode.sv
  - sq_cmd_pack.sv
  - ack_unpack.sv
  - rdma_cmd_bridge.sv
  - target: test
    files:
      - tb_rdma_cmd_bridge.sv

/* rdma_cmd_bridge_testdata.txt */
// 1 opcode pid vfid vaddr len host last cmd legal; cmd groups: len<<2, vaddr<<2|last<<1|host, qpn, op
// 2 opcode pid vfid ack_word 0 host last 0 1; opcode to last are the expected completion fields
1 00 01 0 000000001000 00000040 0 0 000000100_0000000000004000_000001_00000000 1
1 01 2A 3 123456789ABC 00001000 1 0 000004000_000048D159E26AF1_0000EA_00000001 1
1 02 3F F FFFFFFFFFFFF FFFFFFFF 1 1 3FFFFFFFC_0003FFFFFFFFFFFF_0003FF_00000002 1
1 03 10 5 00ABCDEF0000 00000200 0 1 000000800_000002AF37BC0002_000150_00000003 1
1 04 07 1 000000002000 00000020 0 0 0 0
1 02 05 1 000000000800 00000010 0 0 000000040_0000000000002000_000045_00000002 1
1 1F 3F F FFFFFFFFFFFF FFFFFFFF 1 1 0 0
1 01 00 8 800000000000 80000000 0 1 200000000_0002000000000002_000200_00000001 1
1 00 11 2 000012340000 00000100 1 1 000000400_0000000048D00003_000091_00000000 1
1 10 2A 3 000000001000 00000040 1 0 0 0
1 03 20 A 000000000004 00000008 1 0 000000020_0000000000000011_0002A0_00000003 1
1 05 01 0 000000000000 00000000 0 1 0 0
1 02 3E 7 0000DEADBEEF 00000FFF 0 0 000003FFC_000000037AB6FBBC_0001FE_00000002 1
1 01 01 0 000000000000 00000000 1 1 000000000_0000000000000003_000001_00000001 1
2 00 01 0 0000000100000000 0 0 0 0 1
2 01 2A 3 010000EA00000001 0 1 0 0 1
2 02 3F F 030003FF00000002 0 1 1 0 1
2 03 10 5 0200015000000003 0 0 1 0 1
2 02 00 0 FCFFFC00FFFFFFE2 0 0 0 0 1
2 01 15 9 0300025500000001 0 1 1 0 1
2 00 3F 0 0200003F12345660 0 0 1 0 1
2 03 00 F 010003C000000003 0 1 0 0 1
